/* common/isaPkg.sv */
package isaPkg;
	localparam int REG_W = 5;
	localparam logic [REG_W-1:0] REG_ZERO = 5'd0;

	// bit positions of the instruction fields.
	localparam int OP_HI = 31;
	localparam int OP_LO = 26;
	localparam int RS_HI = 25;
	localparam int RS_LO = 21;
	localparam int RT_HI = 20;
	localparam int RT_LO = 16;
	localparam int RD_HI = 15;
	localparam int RD_LO = 11;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;
	localparam int FUNCT_HI = 5;
	localparam int FUNCT_LO = 0;

	localparam logic [5:0] OP_SPECIAL = 6'h00; // R-type with the operation in funct.
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;
endpackage

/* common/cpuPkg.sv */
package cpuPkg;
	localparam int XLEN = 32;
	localparam logic [XLEN-1:0] RESET_PC = 32'hbfc00000;
	localparam int ADDR_MASK_BITS = 29; // physical window on data accesses.
	localparam int WEN_W = 4;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} aluOpT;

	// source of an execute operand.
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwdSelT;
endpackage

/* decode/regFile.sv */
`timescale 1ns/10ps

module regFile (
	input  logic clk,
	input  logic rst_i,
	input  logic [isaPkg::REG_W-1:0] raddrA_i,
	input  logic [isaPkg::REG_W-1:0] raddrB_i,
	input  logic we_i,
	input  logic [isaPkg::REG_W-1:0] waddr_i,
	input  logic [cpuPkg::XLEN-1:0] wdata_i,
	output logic [cpuPkg::XLEN-1:0] rdataA_o,
	output logic [cpuPkg::XLEN-1:0] rdataB_o
);
	logic [cpuPkg::XLEN-1:0] regs [2**isaPkg::REG_W];

	// a same-cycle write is seen by the reader.
	function automatic logic [cpuPkg::XLEN-1:0] readReg(input logic [isaPkg::REG_W-1:0] addr);
		if (addr == isaPkg::REG_ZERO) return '0;
		if (we_i && waddr_i == addr) return wdata_i;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 2**isaPkg::REG_W; i++) regs[i] <= '0;
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdataA_o = readReg(raddrA_i);
		rdataB_o = readReg(raddrB_i);
	end
endmodule

/* decode/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
	input  logic clk,
	input  logic rst_i,
	input  logic stall_i,
	input  logic [cpuPkg::XLEN-1:0] instr_i,
	input  logic [cpuPkg::XLEN-1:0] pcD_i,
	input  logic fwdAD_i,
	input  logic fwdBD_i,
	input  logic [cpuPkg::XLEN-1:0] aluResultM_i,
	input  logic wbWe_i,
	input  logic [isaPkg::REG_W-1:0] wbReg_i,
	input  logic [cpuPkg::XLEN-1:0] wbData_i,
	output logic branchTaken_o,
	output logic [cpuPkg::XLEN-1:0] branchTarget_o,
	output logic isBranch_o,
	output logic [isaPkg::REG_W-1:0] rsD_o,
	output logic [isaPkg::REG_W-1:0] rtD_o,
	output logic useRsD_o,
	output logic useRtD_o,
	output cpuPkg::aluOpT aluOpE_o,
	output logic [cpuPkg::XLEN-1:0] srcAE_o,
	output logic [cpuPkg::XLEN-1:0] srcBE_o,
	output logic [cpuPkg::XLEN-1:0] immE_o,
	output logic immSelE_o,
	output logic [isaPkg::REG_W-1:0] writeRegE_o,
	output logic regWriteE_o,
	output logic memReadE_o,
	output logic memWriteE_o,
	output logic [isaPkg::REG_W-1:0] rsE_o,
	output logic [isaPkg::REG_W-1:0] rtE_o,
	output logic [cpuPkg::XLEN-1:0] pcE_o
);
	logic instrValid;
	logic [cpuPkg::XLEN-1:0] instr, rsVal, rtVal, cmpA, cmpB, immExt;
	logic [5:0] opcode, funct;
	logic [15:0] imm16;
	logic [isaPkg::REG_W-1:0] writeReg;
	logic [7:0] ctrl;
	cpuPkg::aluOpT aluOp;
	logic rdWrite, immSel, signExt, memRead, memWrite, regWrite;

	// the SRAM word is stale on the first cycle out of reset.
	always_ff @(posedge clk) begin
		instrValid <= !rst_i;
	end

	assign instr = instrValid ? instr_i : '0;
	assign opcode = instr[isaPkg::OP_HI:isaPkg::OP_LO];
	assign funct = instr[isaPkg::FUNCT_HI:isaPkg::FUNCT_LO];
	assign imm16 = instr[isaPkg::IMM_HI:isaPkg::IMM_LO];
	assign rsD_o = instr[isaPkg::RS_HI:isaPkg::RS_LO];
	assign rtD_o = instr[isaPkg::RT_HI:isaPkg::RT_LO];

	// ctrl is {regWrite, immSel, signExt, memRead, memWrite, useRs, useRt, branch}.
	always_comb begin
		aluOp = cpuPkg::ALU_ADD;
		case (opcode)
			isaPkg::OP_SPECIAL: ctrl = 8'b1_0_0_0_0_1_1_0;
			isaPkg::OP_ADDIU: ctrl = 8'b1_1_1_0_0_1_0_0;
			isaPkg::OP_ORI: ctrl = 8'b1_1_0_0_0_1_0_0;
			isaPkg::OP_LUI: ctrl = 8'b1_1_0_0_0_0_0_0;
			isaPkg::OP_LW: ctrl = 8'b1_1_1_1_0_1_0_0;
			isaPkg::OP_SW: ctrl = 8'b0_1_1_0_1_1_1_0;
			isaPkg::OP_BEQ, isaPkg::OP_BNE: ctrl = 8'b0_0_1_0_0_1_1_1;
			default: ctrl = '0;
		endcase
		if (opcode == isaPkg::OP_ORI) aluOp = cpuPkg::ALU_OR;
		if (opcode == isaPkg::OP_LUI) aluOp = cpuPkg::ALU_LUI;
		if (opcode == isaPkg::OP_SPECIAL) begin
			case (funct)
				isaPkg::FN_ADDU: aluOp = cpuPkg::ALU_ADD;
				isaPkg::FN_SUBU: aluOp = cpuPkg::ALU_SUB;
				isaPkg::FN_AND: aluOp = cpuPkg::ALU_AND;
				isaPkg::FN_OR: aluOp = cpuPkg::ALU_OR;
				isaPkg::FN_SLT: aluOp = cpuPkg::ALU_SLT;
				default: ctrl = '0; // nop and unsupported functs.
			endcase
		end
	end

	assign {rdWrite, immSel, signExt, memRead, memWrite, useRsD_o, useRtD_o, isBranch_o} = ctrl;
	assign writeReg = (opcode == isaPkg::OP_SPECIAL) ? instr[isaPkg::RD_HI:isaPkg::RD_LO] : rtD_o;
	assign regWrite = rdWrite && (writeReg != isaPkg::REG_ZERO);
	assign immExt = {{(cpuPkg::XLEN-16){signExt & imm16[15]}}, imm16};

	regFile rf (
		.clk(clk), .rst_i(rst_i),
		.raddrA_i(rsD_o), .raddrB_i(rtD_o),
		.we_i(wbWe_i), .waddr_i(wbReg_i), .wdata_i(wbData_i),
		.rdataA_o(rsVal), .rdataB_o(rtVal)
	);

	// WB values already come through the regfile for the branch compare.
	assign cmpA = fwdAD_i ? aluResultM_i : rsVal;
	assign cmpB = fwdBD_i ? aluResultM_i : rtVal;
	assign branchTaken_o = isBranch_o && ((cmpA == cmpB) == (opcode == isaPkg::OP_BEQ));
	assign branchTarget_o = pcD_i + 'd4 + {immExt[cpuPkg::XLEN-3:0], 2'b00};

	always_ff @(posedge clk) begin
		if (rst_i || stall_i) begin
			regWriteE_o <= 1'b0; // bubble.
			memReadE_o <= 1'b0;
			memWriteE_o <= 1'b0;
		end else begin
			regWriteE_o <= regWrite;
			memReadE_o <= memRead;
			memWriteE_o <= memWrite;
		end
		aluOpE_o <= aluOp;
		srcAE_o <= rsVal;
		srcBE_o <= rtVal;
		immE_o <= immExt;
		immSelE_o <= immSel;
		writeRegE_o <= writeReg;
		rsE_o <= rsD_o;
		rtE_o <= rtD_o;
		pcE_o <= pcD_i;
	end
endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/10ps

module fetchStage (
	input  logic clk,
	input  logic rst_i,
	input  logic stall_i,
	input  logic branchTaken_i,
	input  logic [cpuPkg::XLEN-1:0] branchTarget_i,
	output logic [cpuPkg::XLEN-1:0] pc_o,
	output logic [cpuPkg::XLEN-1:0] pcD_o
);
	logic [cpuPkg::XLEN-1:0] pcNext;

	// the word fetched now is the delay slot, so the redirect applies to the one after.
	assign pcNext = branchTaken_i ? branchTarget_i : pc_o + 'd4;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_o <= cpuPkg::RESET_PC;
		end else if (!stall_i) begin
			pc_o <= pcNext;
			pcD_o <= pc_o; // pc of the word the SRAM returns next cycle.
		end
	end
endmodule

/* hdl/executeStage.sv */
`timescale 1ns/10ps

module executeStage (
	input  logic clk,
	input  logic rst_i,
	input  cpuPkg::aluOpT aluOpE_i,
	input  logic [cpuPkg::XLEN-1:0] srcAE_i,
	input  logic [cpuPkg::XLEN-1:0] srcBE_i,
	input  logic [cpuPkg::XLEN-1:0] immE_i,
	input  logic immSelE_i,
	input  logic [isaPkg::REG_W-1:0] writeRegE_i,
	input  logic regWriteE_i,
	input  logic memReadE_i,
	input  logic memWriteE_i,
	input  logic [cpuPkg::XLEN-1:0] pcE_i,
	input  cpuPkg::fwdSelT fwdAE_i,
	input  cpuPkg::fwdSelT fwdBE_i,
	input  logic [cpuPkg::XLEN-1:0] aluResultM_i,
	input  logic [cpuPkg::XLEN-1:0] wbData_i,
	output logic [cpuPkg::XLEN-1:0] aluResult_o,
	output logic [cpuPkg::XLEN-1:0] aluResultM_o,
	output logic [cpuPkg::XLEN-1:0] storeDataM_o,
	output logic [isaPkg::REG_W-1:0] writeRegM_o,
	output logic regWriteM_o,
	output logic memReadM_o,
	output logic memWriteM_o,
	output logic [cpuPkg::XLEN-1:0] pcM_o
);
	logic [cpuPkg::XLEN-1:0] opA, opB, aluB;

	function automatic logic [cpuPkg::XLEN-1:0] fwdMux(input cpuPkg::fwdSelT sel,
			input logic [cpuPkg::XLEN-1:0] regVal);
		case (sel)
			cpuPkg::FWD_MEM: return aluResultM_i;
			cpuPkg::FWD_WB: return wbData_i;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		opA = fwdMux(fwdAE_i, srcAE_i);
		opB = fwdMux(fwdBE_i, srcBE_i); // also the store data.
		aluB = immSelE_i ? immE_i : opB;
		case (aluOpE_i)
			cpuPkg::ALU_SUB: aluResult_o = opA - aluB;
			cpuPkg::ALU_AND: aluResult_o = opA & aluB;
			cpuPkg::ALU_OR: aluResult_o = opA | aluB;
			cpuPkg::ALU_SLT: aluResult_o = {{(cpuPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			cpuPkg::ALU_LUI: aluResult_o = {aluB[15:0], {(cpuPkg::XLEN-16){1'b0}}};
			default: aluResult_o = opA + aluB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			regWriteM_o <= 1'b0;
			memReadM_o <= 1'b0;
			memWriteM_o <= 1'b0;
		end else begin
			regWriteM_o <= regWriteE_i;
			memReadM_o <= memReadE_i;
			memWriteM_o <= memWriteE_i;
		end
		aluResultM_o <= aluResult_o;
		storeDataM_o <= opB;
		writeRegM_o <= writeRegE_i;
		pcM_o <= pcE_i;
	end
endmodule

/* hdl/memWbStage.sv */
`timescale 1ns/10ps

module memWbStage (
	input  logic clk,
	input  logic rst_i,
	input  logic [cpuPkg::XLEN-1:0] aluResultM_i,
	input  logic [cpuPkg::XLEN-1:0] storeDataM_i,
	input  logic [isaPkg::REG_W-1:0] writeRegM_i,
	input  logic regWriteM_i,
	input  logic memReadM_i,
	input  logic memWriteM_i,
	input  logic [cpuPkg::XLEN-1:0] pcM_i,
	input  logic [cpuPkg::XLEN-1:0] dataSramRdata_i,
	output logic [cpuPkg::WEN_W-1:0] dataSramWen_o,
	output logic [cpuPkg::XLEN-1:0] dataSramAddr_o,
	output logic [cpuPkg::XLEN-1:0] dataSramWdata_o,
	output logic wbWe_o,
	output logic [isaPkg::REG_W-1:0] wbReg_o,
	output logic [cpuPkg::XLEN-1:0] wbData_o,
	output logic [cpuPkg::XLEN-1:0] wbPc_o
);
	logic memReadW;
	logic [cpuPkg::XLEN-1:0] aluResultW;

	assign dataSramWen_o = {cpuPkg::WEN_W{memWriteM_i}}; // word stores only.
	assign dataSramAddr_o = {{(cpuPkg::XLEN-cpuPkg::ADDR_MASK_BITS){1'b0}},
		aluResultM_i[cpuPkg::ADDR_MASK_BITS-1:0]};
	assign dataSramWdata_o = storeDataM_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wbWe_o <= 1'b0;
			memReadW <= 1'b0;
		end else begin
			wbWe_o <= regWriteM_i;
			memReadW <= memReadM_i;
		end
		aluResultW <= aluResultM_i;
		wbReg_o <= writeRegM_i;
		wbPc_o <= pcM_i;
	end

	// load data shows up from the SRAM in this cycle.
	assign wbData_o = memReadW ? dataSramRdata_i : aluResultW;
endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
	input  logic [isaPkg::REG_W-1:0] rsD_i,
	input  logic [isaPkg::REG_W-1:0] rtD_i,
	input  logic useRsD_i,
	input  logic useRtD_i,
	input  logic isBranch_i,
	input  logic [isaPkg::REG_W-1:0] rsE_i,
	input  logic [isaPkg::REG_W-1:0] rtE_i,
	input  logic [isaPkg::REG_W-1:0] writeRegE_i,
	input  logic regWriteE_i,
	input  logic memReadE_i,
	input  logic [isaPkg::REG_W-1:0] writeRegM_i,
	input  logic regWriteM_i,
	input  logic memReadM_i,
	input  logic [isaPkg::REG_W-1:0] wbReg_i,
	input  logic wbWe_i,
	output logic stall_o,
	output logic fwdAD_o,
	output logic fwdBD_o,
	output cpuPkg::fwdSelT fwdAE_o,
	output cpuPkg::fwdSelT fwdBE_o
);
	logic depE, depM;

	// newest producer wins.
	function automatic cpuPkg::fwdSelT fwdSel(input logic [isaPkg::REG_W-1:0] src);
		if (regWriteM_i && writeRegM_i == src) return cpuPkg::FWD_MEM;
		if (wbWe_i && wbReg_i == src) return cpuPkg::FWD_WB;
		return cpuPkg::FWD_REG;
	endfunction

	always_comb begin
		fwdAE_o = fwdSel(rsE_i);
		fwdBE_o = fwdSel(rtE_i);
		depE = regWriteE_i && ((useRsD_i && rsD_i == writeRegE_i) ||
			(useRtD_i && rtD_i == writeRegE_i));
		depM = regWriteM_i && ((useRsD_i && rsD_i == writeRegM_i) ||
			(useRtD_i && rtD_i == writeRegM_i));
		// branches compare in decode so they wait for EX results, and loads until WB.
		stall_o = (depE && (memReadE_i || isBranch_i)) || (depM && memReadM_i && isBranch_i);
		fwdAD_o = regWriteM_i && !memReadM_i && rsD_i == writeRegM_i;
		fwdBD_o = regWriteM_i && !memReadM_i && rtD_i == writeRegM_i;
	end
endmodule

/* hdl/mycpuTop.sv */
`timescale 1ns/10ps

module mycpuTop (
	input  logic clk,
	input  logic rst_i,
	input  logic [cpuPkg::XLEN-1:0] instSramRdata_i,
	input  logic [cpuPkg::XLEN-1:0] dataSramRdata_i,
	output logic instSramEn_o,
	output logic [cpuPkg::WEN_W-1:0] instSramWen_o,
	output logic [cpuPkg::XLEN-1:0] instSramAddr_o,
	output logic [cpuPkg::XLEN-1:0] instSramWdata_o,
	output logic dataSramEn_o,
	output logic [cpuPkg::WEN_W-1:0] dataSramWen_o,
	output logic [cpuPkg::XLEN-1:0] dataSramAddr_o,
	output logic [cpuPkg::XLEN-1:0] dataSramWdata_o,
	output logic [cpuPkg::XLEN-1:0] debugWbPc_o,
	output logic [cpuPkg::WEN_W-1:0] debugWbRfWen_o,
	output logic [isaPkg::REG_W-1:0] debugWbRfWnum_o,
	output logic [cpuPkg::XLEN-1:0] debugWbRfWdata_o
);
	logic stall, branchTaken, isBranch, useRsD, useRtD, fwdAD, fwdBD;
	logic [cpuPkg::XLEN-1:0] branchTarget, pcD;
	logic [isaPkg::REG_W-1:0] rsD, rtD;

	cpuPkg::aluOpT aluOpE;
	logic [cpuPkg::XLEN-1:0] srcAE, srcBE, immE, pcE;
	logic immSelE, regWriteE, memReadE, memWriteE;
	logic [isaPkg::REG_W-1:0] writeRegE, rsE, rtE;
	cpuPkg::fwdSelT fwdAE, fwdBE;

	logic [cpuPkg::XLEN-1:0] aluResultM, storeDataM, pcM;
	logic [isaPkg::REG_W-1:0] writeRegM;
	logic regWriteM, memReadM, memWriteM;

	logic wbWe;
	logic [isaPkg::REG_W-1:0] wbReg;
	logic [cpuPkg::XLEN-1:0] wbData, wbPc;

	assign instSramEn_o = !rst_i && !stall; // a held enable keeps the decode word.
	assign instSramWen_o = '0;
	assign instSramWdata_o = '0;
	assign dataSramEn_o = !rst_i;
	assign debugWbPc_o = wbPc;
	assign debugWbRfWen_o = {cpuPkg::WEN_W{wbWe}};
	assign debugWbRfWnum_o = wbReg;
	assign debugWbRfWdata_o = wbData;

	fetchStage fetch (
		.clk(clk), .rst_i(rst_i), .stall_i(stall),
		.branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
		.pc_o(instSramAddr_o), .pcD_o(pcD)
	);

	decodeStage decode (
		.clk(clk), .rst_i(rst_i), .stall_i(stall),
		.instr_i(instSramRdata_i), .pcD_i(pcD),
		.fwdAD_i(fwdAD), .fwdBD_i(fwdBD), .aluResultM_i(aluResultM),
		.wbWe_i(wbWe), .wbReg_i(wbReg), .wbData_i(wbData),
		.branchTaken_o(branchTaken), .branchTarget_o(branchTarget), .isBranch_o(isBranch),
		.rsD_o(rsD), .rtD_o(rtD), .useRsD_o(useRsD), .useRtD_o(useRtD),
		.aluOpE_o(aluOpE), .srcAE_o(srcAE), .srcBE_o(srcBE),
		.immE_o(immE), .immSelE_o(immSelE), .writeRegE_o(writeRegE),
		.regWriteE_o(regWriteE), .memReadE_o(memReadE), .memWriteE_o(memWriteE),
		.rsE_o(rsE), .rtE_o(rtE), .pcE_o(pcE)
	);

	executeStage execute (
		.clk(clk), .rst_i(rst_i),
		.aluOpE_i(aluOpE), .srcAE_i(srcAE), .srcBE_i(srcBE),
		.immE_i(immE), .immSelE_i(immSelE), .writeRegE_i(writeRegE),
		.regWriteE_i(regWriteE), .memReadE_i(memReadE), .memWriteE_i(memWriteE),
		.pcE_i(pcE), .fwdAE_i(fwdAE), .fwdBE_i(fwdBE),
		.aluResultM_i(aluResultM), .wbData_i(wbData),
		.aluResult_o(), .aluResultM_o(aluResultM), .storeDataM_o(storeDataM),
		.writeRegM_o(writeRegM), .regWriteM_o(regWriteM),
		.memReadM_o(memReadM), .memWriteM_o(memWriteM), .pcM_o(pcM)
	);

	memWbStage memWb (
		.clk(clk), .rst_i(rst_i),
		.aluResultM_i(aluResultM), .storeDataM_i(storeDataM), .writeRegM_i(writeRegM),
		.regWriteM_i(regWriteM), .memReadM_i(memReadM), .memWriteM_i(memWriteM),
		.pcM_i(pcM), .dataSramRdata_i(dataSramRdata_i),
		.dataSramWen_o(dataSramWen_o), .dataSramAddr_o(dataSramAddr_o),
		.dataSramWdata_o(dataSramWdata_o),
		.wbWe_o(wbWe), .wbReg_o(wbReg), .wbData_o(wbData), .wbPc_o(wbPc)
	);

	hazardUnit hazard (
		.rsD_i(rsD), .rtD_i(rtD), .useRsD_i(useRsD), .useRtD_i(useRtD),
		.isBranch_i(isBranch),
		.rsE_i(rsE), .rtE_i(rtE), .writeRegE_i(writeRegE),
		.regWriteE_i(regWriteE), .memReadE_i(memReadE),
		.writeRegM_i(writeRegM), .regWriteM_i(regWriteM), .memReadM_i(memReadM),
		.wbReg_i(wbReg), .wbWe_i(wbWe),
		.stall_o(stall), .fwdAD_o(fwdAD), .fwdBD_o(fwdBD),
		.fwdAE_o(fwdAE), .fwdBE_o(fwdBE)
	);
endmodule

/* test/mycpu_chk.sv */
`timescale 1ns/10ps

module mycpuChk (
	input  logic clk,
	input  logic rst_i,
	input  logic instSramEn_i,
	input  logic [cpuPkg::XLEN-1:0] instSramAddr_i,
	input  logic dataSramEn_i,
	input  logic [cpuPkg::WEN_W-1:0] dataSramWen_i,
	input  logic [cpuPkg::WEN_W-1:0] debugWbRfWen_i,
	input  logic [isaPkg::REG_W-1:0] debugWbRfWnum_i
);
	wenWhole: assert property (@(posedge clk) disable iff (rst_i)
		dataSramWen_i == '0 || dataSramWen_i == '1)
		else $error("data SRAM byte enables are neither all off nor all on");

	// register 0 is never written back.
	wbNonZero: assert property (@(posedge clk) disable iff (rst_i)
		debugWbRfWen_i != '0 |-> debugWbRfWnum_i != '0)
		else $error("writeback trace shows register 0");

	fetchAligned: assert property (@(posedge clk) disable iff (rst_i)
		instSramAddr_i[1:0] == 2'b00)
		else $error("instruction address is not word aligned");

	ctrlKnown: assert property (@(posedge clk) disable iff (rst_i)
		!$isunknown({instSramEn_i, dataSramEn_i, dataSramWen_i, debugWbRfWen_i}))
		else $error("control output is unknown");
endmodule

bind mycpuTop mycpuChk chk (
	.clk(clk), .rst_i(rst_i),
	.instSramEn_i(instSramEn_o), .instSramAddr_i(instSramAddr_o),
	.dataSramEn_i(dataSramEn_o), .dataSramWen_i(dataSramWen_o),
	.debugWbRfWen_i(debugWbRfWen_o), .debugWbRfWnum_i(debugWbRfWnum_o)
);

/* test/mycpuTb.sv */
`timescale 1ns/10ps

module mycpuTb;
	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 10;
	localparam int RUN_TIMEOUT = 2000;
	localparam int SETTLE_CYCLES = 12;
	localparam logic [31:0] BOOT_PC = 32'hbfc00000;
	localparam logic [31:0] SEED = 32'h3b8da33c;

	logic clk;
	logic rst;
	logic [31:0] instRdata, dataRdata;
	logic instEn, dataEn;
	logic [3:0] instWen, dataWen, wbWen;
	logic [31:0] instAddr, instWdata, dataAddr, dataWdata, wbPc, wbData;
	logic [4:0] wbNum;

	logic [31:0] instMem [64];
	logic [31:0] dataMem [256];
	logic [31:0] expWbPc [$];
	logic [31:0] expWbReg [$];
	logic [31:0] expWbData [$];
	logic [31:0] expStAddr [$];
	logic [31:0] expStData [$];
	int expWbTotal, expStTotal;
	int errors = 0;
	int checks = 0;
	int retired = 0;
	int stores = 0;
	int cycleCount = 0;
	bit firstFetch = 1'b1;

	mycpuTop DUT (
		.clk(clk), .rst_i(rst),
		.instSramRdata_i(instRdata), .dataSramRdata_i(dataRdata),
		.instSramEn_o(instEn), .instSramWen_o(instWen),
		.instSramAddr_o(instAddr), .instSramWdata_o(instWdata),
		.dataSramEn_o(dataEn), .dataSramWen_o(dataWen),
		.dataSramAddr_o(dataAddr), .dataSramWdata_o(dataWdata),
		.debugWbPc_o(wbPc), .debugWbRfWen_o(wbWen),
		.debugWbRfWnum_o(wbNum), .debugWbRfWdata_o(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// records are I (program word), W (writeback) and S (store); # starts a comment.
	task automatic loadGolden();
		int fd, n, need, ch;
		byte kind;
		logic [31:0] a, b, c;
		fd = $fopen("test/mycpu_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden file test/mycpu_golden.txt");
			return;
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			n = 0;
			need = 0;
			case (kind)
				"#": begin
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1) ch = $fgetc(fd);
				end
				"I": begin
					need = 2;
					n = $fscanf(fd, "%h %h", a, b);
					instMem[a[7:2]] = b;
				end
				"W": begin
					need = 3;
					n = $fscanf(fd, "%h %h %h", a, b, c);
					expWbPc.push_back(a);
					expWbReg.push_back(b);
					expWbData.push_back(c);
				end
				"S": begin
					need = 2;
					n = $fscanf(fd, "%h %h", a, b);
					expStAddr.push_back(a);
					expStData.push_back(b);
				end
				default: begin
					errors++;
					$display("golden file holds a record of unknown kind");
				end
			endcase
			if (n != need) begin
				errors++;
				$display("golden file record of kind %c is missing fields", kind);
			end
		end
		$fclose(fd);
	endtask

	// SRAM models, reset checks and the trace and store compare.
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= 1 && cycleCount <= RESET_CYCLES) begin
			check("reset writeback enable", 32'd0, 32'(wbWen));
			check("reset store enable", 32'd0, 32'(dataWen));
		end
		if (cycleCount >= 1 && cycleCount < RESET_CYCLES) begin
			check("reset fetch enable", 32'd0, 32'(instEn));
			check("reset data enable", 32'd0, 32'(dataEn));
		end
		if (cycleCount >= RESET_CYCLES) begin
			check("data enable out of reset", 32'd1, 32'(dataEn));
		end
		if (instEn) begin
			if (firstFetch) begin
				check("first fetch address", BOOT_PC, instAddr);
				firstFetch = 1'b0;
			end
			check("instruction SRAM write enable", 32'd0, 32'(instWen));
			check("instruction SRAM write data", 32'd0, instWdata);
			instRdata <= instMem[instAddr[7:2]];
		end
		if (dataEn) begin
			if (dataWen != '0) begin
				if (expStAddr.size() == 0) begin
					errors++;
					$display("store to %h is not in the golden list", dataAddr);
				end else begin
					check($sformatf("store %0d address", stores), expStAddr.pop_front(), dataAddr);
					check($sformatf("store %0d data", stores), expStData.pop_front(), dataWdata);
				end
				stores++;
				dataMem[dataAddr[9:2]] <= dataWdata; // the enables are all on for a whole word.
			end
			dataRdata <= dataMem[dataAddr[9:2]];
		end
		if (wbWen != '0) begin
			if (expWbPc.size() == 0) begin
				errors++;
				$display("writeback at pc %h is not in the golden trace", wbPc);
			end else begin
				check($sformatf("writeback %0d pc", retired), expWbPc.pop_front(), wbPc);
				check($sformatf("writeback %0d register", retired), expWbReg.pop_front(),
					32'(wbNum));
				check($sformatf("writeback %0d data", retired), expWbData.pop_front(), wbData);
			end
			retired++;
		end
	end

	initial begin
		int waitCycles;
		rst <= 1'b1;
		instRdata <= '0;
		dataRdata <= '0;
		for (int i = 0; i < 64; i++) instMem[i] = '0; // nop fill.
		for (int i = 0; i < 256; i++) dataMem[i] = xorshift(SEED ^ (i << 2));
		loadGolden();
		expWbTotal = expWbPc.size();
		expStTotal = expStAddr.size();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		waitCycles = 0;
		while ((retired < expWbTotal || stores < expStTotal) && waitCycles < RUN_TIMEOUT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (retired < expWbTotal || stores < expStTotal) begin
			errors++;
			$display("timeout: expected retire count was not reached (%0d of %0d, stores %0d of %0d)",
				retired, expWbTotal, stores, expStTotal);
		end

		// the program spins on a branch to itself, so nothing more should retire.
		waitCycles = 0;
		while (waitCycles < SETTLE_CYCLES) begin
			@(negedge clk);
			waitCycles++;
		end
		check("retired count", 32'(expWbTotal), 32'(retired));
		check("store count", 32'(expStTotal), 32'(stores));

		$display("checks %0d, errors %0d, writebacks %0d, stores %0d",
			checks, errors, retired, stores);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end
endmodule

/* mycpu.f */
common/isaPkg.sv
common/cpuPkg.sv
decode/regFile.sv
decode/decodeStage.sv
hdl/fetchStage.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/hazardUnit.sv
hdl/mycpuTop.sv
test/mycpu_chk.sv
test/mycpuTb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module mycpuTb -Mdir obj_dir -o mycpuSim -f mycpu.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mycpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
	exit 0
fi
exit 1

/* test/mycpu_golden.txt */
# I addr word: program image. W pc reg data: writeback trace in retire order.
# S addr data: data SRAM stores in order, address after the 29-bit mask.
I bfc00000 3c011234
I bfc00004 34215678
I bfc00008 2402fff8
I bfc0000c 00221821
I bfc00010 00612023
I bfc00014 00642824
I bfc00018 0085302a
I bfc0001c 00c10025
I bfc00020 00063821
I bfc00024 3c08a000
I bfc00028 ad030010
I bfc0002c 8d090010
I bfc00030 01275021
I bfc00034 ad0a0014
I bfc00038 8d0b0014
I bfc0003c 116a0002
I bfc00040 240c0005
I bfc00044 240c0007
I bfc00048 258d0001
I bfc0004c 15ac0002
I bfc00050 35ae0030
I bfc00054 240e0099
I bfc00058 11cd0003
I bfc0005c 01cd782a
I bfc00060 15e00002
I bfc00064 01cf8021
I bfc00068 26110001
I bfc0006c 1000ffff
I bfc00070 00000000
W bfc00000 01 12340000
W bfc00004 01 12345678
W bfc00008 02 fffffff8
W bfc0000c 03 12345670
W bfc00010 04 fffffff8
W bfc00014 05 12345670
W bfc00018 06 00000001
W bfc00020 07 00000001
W bfc00024 08 a0000000
W bfc0002c 09 12345670
W bfc00030 0a 12345671
W bfc00038 0b 12345671
W bfc00040 0c 00000005
W bfc00048 0d 00000006
W bfc00050 0e 00000036
W bfc0005c 0f 00000000
W bfc00064 10 00000036
W bfc00068 11 00000037
S 00000010 12345670
S 00000014 12345671
